/* project.f */
hdl/btb_cfg_pkg.sv
hdl/btb_types_pkg.sv
hdl/btb_table.sv
hdl/btb_commit_select.sv
hdl/btb_ras.sv
hdl/btb_next_pc.sv
hdl/btb_top.sv
verif/btb_properties.sv
verif/btb_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and decide the result from its output
cd "$(dirname "$0")" || exit 1
sim_out=""
verilator --binary --timing --assert -Wno-fatal --top-module btb_tb -f project.f -o btb_sim &&
	sim_out="$(./obj_dir/btb_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "TESTS PASSED" && echo "run.sh: simulation passed" ||
	{ echo "run.sh: simulation failed"; exit 1; }

/* verif/btb_tb.sv */
// Table-driven testbench for the fetch predictor, run as simulation top with bound property checks
`timescale 1ns/1ps
`default_nettype none

module btb_tb;

	typedef logic [btb_cfg_pkg::PC_WIDTH-1:0] addr_t;

	// One stimulus row with the response it should produce
	typedef struct packed {
		logic                                  adv;
		logic                                  bm;         // Commit-stage branch miss
		addr_t                                 miss_pc;
		logic                                  dec;        // Decode redirect request
		addr_t                                 dec_pc;
		logic                                  ovr;        // External override
		addr_t                                 ext_pc;
		logic [3:0][2:0]                       kind;       // Commit slots, index = slot
		logic [3:0][btb_cfg_pkg::PC_WIDTH-1:0] src;
		logic [3:0][btb_cfg_pkg::PC_WIDTH-1:0] tgt;
		logic [3:0]                            tk;
		addr_t                                 exp_pc;     // fetch_pc after the edge
		logic                                  exp_takb;   // takb during the row
	} step_t;

	logic  clk;
	logic  rst;
	logic  advance, branchmiss, predicted_correctly_dec, p_override;
	addr_t misspc, new_address_dec, new_address_ext;
	btb_types_pkg::flow_kind_e commit_kind_0, commit_kind_1, commit_kind_2, commit_kind_3;
	addr_t commit_pc_0, commit_pc_1, commit_pc_2, commit_pc_3;
	addr_t commit_tgt_0, commit_tgt_1, commit_tgt_2, commit_tgt_3;
	logic  commit_takb_0, commit_takb_1, commit_takb_2, commit_takb_3;
	addr_t fetch_pc;
	logic  takb;

	step_t steps[$];      // Stimulus table
	step_t cur;           // Row under construction
	int    errors      = 0;
	int    checks      = 0;
	int    cycle_count = 0;
	int    cycle_limit = 0;

	btb_top btb_top_inst (
		.clk(clk), .rst(rst), .advance(advance),
		.branchmiss(branchmiss), .misspc(misspc),
		.predicted_correctly_dec(predicted_correctly_dec), .new_address_dec(new_address_dec),
		.p_override(p_override), .new_address_ext(new_address_ext),
		.commit_kind_0(commit_kind_0), .commit_pc_0(commit_pc_0),
		.commit_tgt_0(commit_tgt_0), .commit_takb_0(commit_takb_0),
		.commit_kind_1(commit_kind_1), .commit_pc_1(commit_pc_1),
		.commit_tgt_1(commit_tgt_1), .commit_takb_1(commit_takb_1),
		.commit_kind_2(commit_kind_2), .commit_pc_2(commit_pc_2),
		.commit_tgt_2(commit_tgt_2), .commit_takb_2(commit_takb_2),
		.commit_kind_3(commit_kind_3), .commit_pc_3(commit_pc_3),
		.commit_tgt_3(commit_tgt_3), .commit_takb_3(commit_takb_3),
		.fetch_pc(fetch_pc), .takb(takb)
	);

	always #50 clk = ~clk;   // 100 ns period

	// Watchdog, limit set once the table is built
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: run went past %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ========================================================================
	// Table construction
	// ========================================================================
	task automatic commit_slot(input int slot, input btb_types_pkg::flow_kind_e kind,
	                           input addr_t src, input addr_t tgt, input logic tk);
		cur.kind[slot] = kind;
		cur.src[slot]  = src;
		cur.tgt[slot]  = tgt;
		cur.tk[slot]   = tk;
	endtask

	task automatic miss_to(input addr_t a);
		cur.bm      = 1'b1;
		cur.miss_pc = a;
	endtask

	task automatic decode_to(input addr_t a);
		cur.dec    = 1'b1;
		cur.dec_pc = a;
	endtask

	task automatic override_to(input addr_t a);
		cur.ovr    = 1'b1;
		cur.ext_pc = a;
	endtask

	// Closes the row, next one starts idle with all slots empty
	task automatic end_row(input logic adv, input addr_t exp_pc, input logic exp_takb);
		cur.adv      = adv;
		cur.exp_pc   = exp_pc;
		cur.exp_takb = exp_takb;
		steps.push_back(cur);
		cur = '0;
	endtask

	task automatic build_table;
		// Sequential steps, hold with advance low
		end_row(1'b1, 32'hFFFC_0018, 1'b0);
		end_row(1'b1, 32'hFFFC_0030, 1'b0);
		end_row(1'b0, 32'hFFFC_0030, 1'b0);
		end_row(1'b0, 32'hFFFC_0030, 1'b0);
		end_row(1'b1, 32'hFFFC_0048, 1'b0);
		// Taken branch at FFFC0090, hits two edges after commit
		commit_slot(0, btb_types_pkg::FLOW_BRANCH, 32'hFFFC_0090, 32'h0000_1000, 1'b1);
		end_row(1'b1, 32'hFFFC_0060, 1'b0);
		end_row(1'b1, 32'hFFFC_0078, 1'b0);
		end_row(1'b1, 32'hFFFC_0090, 1'b0);
		commit_slot(0, btb_types_pkg::FLOW_BRANCH, 32'h0000_1030, 32'h0000_2000, 1'b0);
		end_row(1'b1, 32'h0000_1000, 1'b1);          // Branch hit, taken
		end_row(1'b1, 32'h0000_1018, 1'b0);
		end_row(1'b1, 32'h0000_1030, 1'b0);
		// Slots 1 and 3 together, only slot 1 lands in the table
		commit_slot(1, btb_types_pkg::FLOW_JUMP, 32'h0000_2030, 32'h0000_3000, 1'b0);
		commit_slot(3, btb_types_pkg::FLOW_JUMP, 32'h0000_2018, 32'h0000_4000, 1'b0);
		end_row(1'b1, 32'h0000_2000, 1'b0);          // Not-taken branch still redirects
		commit_slot(0, btb_types_pkg::FLOW_CALL, 32'h0000_5000, 32'h0000_6048, 1'b0);
		end_row(1'b1, 32'h0000_2018, 1'b0);
		commit_slot(0, btb_types_pkg::FLOW_CALL, 32'h0000_3018, 32'h0000_5000, 1'b0);
		end_row(1'b1, 32'h0000_2030, 1'b0);          // Dropped slot 3 entry misses
		commit_slot(0, btb_types_pkg::FLOW_RET, 32'h0000_6048, 32'h0, 1'b0);
		end_row(1'b1, 32'h0000_3000, 1'b0);          // Jump hit
		commit_slot(0, btb_types_pkg::FLOW_RET, 32'h0000_5030, 32'h0, 1'b0);
		end_row(1'b1, 32'h0000_3018, 1'b0);
		// Nested calls, returns come back last in first out
		end_row(1'b1, 32'h0000_5000, 1'b0);          // Pushes 3030
		end_row(1'b1, 32'h0000_6048, 1'b0);          // Pushes 5018
		end_row(1'b1, 32'h0000_5018, 1'b0);
		end_row(1'b1, 32'h0000_5030, 1'b0);
		end_row(1'b1, 32'h0000_3030, 1'b0);
		// Redirect priority on the call hit at 3018
		miss_to(32'h0000_3018);
		end_row(1'b1, 32'h0000_3018, 1'b0);
		miss_to(32'h0000_7000);
		decode_to(32'h0000_7100);
		override_to(32'h0000_7200);
		end_row(1'b1, 32'h0000_7000, 1'b0);
		override_to(32'h0000_3018);
		end_row(1'b1, 32'h0000_3018, 1'b0);
		decode_to(32'h0000_7100);
		override_to(32'h0000_7200);
		end_row(1'b1, 32'h0000_7100, 1'b0);
		override_to(32'h0000_3018);
		end_row(1'b1, 32'h0000_3018, 1'b0);
		override_to(32'h0000_7200);
		end_row(1'b1, 32'h0000_7200, 1'b0);
		override_to(32'h0000_6048);
		end_row(1'b1, 32'h0000_6048, 1'b0);
		end_row(1'b1, 32'hFFFC_0000, 1'b0);          // Empty stack, no push leaked
		end_row(1'b0, 32'hFFFC_0000, 1'b0);
		override_to(32'h0000_3018);
		end_row(1'b1, 32'h0000_3018, 1'b0);
		end_row(1'b0, 32'h0000_3018, 1'b0);          // Call hit held off
		end_row(1'b1, 32'h0000_5000, 1'b0);
	endtask

	// ========================================================================
	// Drive and check
	// ========================================================================
	task automatic drive_inputs(input step_t s);
		advance                 = s.adv;
		branchmiss              = s.bm;
		misspc                  = s.miss_pc;
		predicted_correctly_dec = !s.dec;
		new_address_dec         = s.dec_pc;
		p_override              = s.ovr;
		new_address_ext         = s.ext_pc;
		commit_kind_0 = btb_types_pkg::flow_kind_e'(s.kind[0]);
		commit_kind_1 = btb_types_pkg::flow_kind_e'(s.kind[1]);
		commit_kind_2 = btb_types_pkg::flow_kind_e'(s.kind[2]);
		commit_kind_3 = btb_types_pkg::flow_kind_e'(s.kind[3]);
		commit_pc_0   = s.src[0];
		commit_pc_1   = s.src[1];
		commit_pc_2   = s.src[2];
		commit_pc_3   = s.src[3];
		commit_tgt_0  = s.tgt[0];
		commit_tgt_1  = s.tgt[1];
		commit_tgt_2  = s.tgt[2];
		commit_tgt_3  = s.tgt[3];
		commit_takb_0 = s.tk[0];
		commit_takb_1 = s.tk[1];
		commit_takb_2 = s.tk[2];
		commit_takb_3 = s.tk[3];
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cur = '0;
		drive_inputs(cur);      // Idle inputs, no correction
		build_table();
		cycle_limit = steps.size() + 20;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		check_addr("fetch_pc", btb_cfg_pkg::RESET_PC, fetch_pc);
		check_bit("takb", 1'b0, takb);
		foreach (steps[i]) begin
			drive_inputs(steps[i]);
			@(negedge clk);
			check_bit("takb", steps[i].exp_takb, takb);   // Lookup of the current fetch_pc
			@(posedge clk);
			#1;
			check_addr("fetch_pc", steps[i].exp_pc, fetch_pc);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/btb_properties.sv */
// Concurrent checks on the return stack and the fetch register, attached to the RTL by bind
`timescale 1ns/1ps
`default_nettype none

module btb_properties (
	input logic                                  clk,
	input logic                                  rst,
	input logic                                  push,
	input logic                                  pop,
	input logic [btb_cfg_pkg::RAS_PTR_WIDTH-1:0] sp,
	input logic                                  advance,
	input logic [btb_cfg_pkg::PC_WIDTH-1:0]      fetch_pc
);

	// A lookup is either a call or a return, never both
	push_pop_exclusive: assert property (@(posedge clk) disable iff (rst) !(push && pop))
		else $error("push and pop high in the same cycle");

	// Pointer moves one step at most per cycle, the wrap counts as one step
	sp_single_step: assert property (@(posedge clk) disable iff (rst)
		(sp == $past(sp)) || (sp == $past(sp) + 1'b1) || (sp == $past(sp) - 1'b1))
		else $error("stack pointer jumped by more than one");

	// Watched address frozen while its stage is stalled
	fetch_hold: assert property (@(posedge clk) disable iff (rst)
		(!$past(advance) && !$past(rst)) |-> (fetch_pc == $past(fetch_pc)))
		else $error("watched address moved while its stage was stalled");

endmodule

// Stack instance watches the top entry, which stays put while no push or pop happens
bind btb_ras btb_properties ras_checks (
	.clk(clk), .rst(rst), .push(push), .pop(pop), .sp(sp),
	.advance(push || pop), .fetch_pc(ras_top)
);

// Fetch register instance, the stack pointer lives in btb_ras
bind btb_next_pc btb_properties fetch_checks (
	.clk(clk), .rst(rst), .push(push), .pop(pop), .sp('0),
	.advance(advance), .fetch_pc(fetch_pc)
);

`default_nettype wire

/* hdl/btb_top.sv */
// Top level of the fetch predictor, connecting target table, commit select, return stack and PC
`timescale 1ns/1ps
`default_nettype none

module btb_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      advance,
	input  logic                      branchmiss,
	input  btb_types_pkg::pc_t        misspc,
	input  logic                      predicted_correctly_dec,
	input  btb_types_pkg::pc_t        new_address_dec,
	input  logic                      p_override,
	input  btb_types_pkg::pc_t        new_address_ext,
	input  btb_types_pkg::flow_kind_e commit_kind_0,
	input  btb_types_pkg::pc_t        commit_pc_0,
	input  btb_types_pkg::pc_t        commit_tgt_0,
	input  logic                      commit_takb_0,
	input  btb_types_pkg::flow_kind_e commit_kind_1,
	input  btb_types_pkg::pc_t        commit_pc_1,
	input  btb_types_pkg::pc_t        commit_tgt_1,
	input  logic                      commit_takb_1,
	input  btb_types_pkg::flow_kind_e commit_kind_2,
	input  btb_types_pkg::pc_t        commit_pc_2,
	input  btb_types_pkg::pc_t        commit_tgt_2,
	input  logic                      commit_takb_2,
	input  btb_types_pkg::flow_kind_e commit_kind_3,
	input  btb_types_pkg::pc_t        commit_pc_3,
	input  btb_types_pkg::pc_t        commit_tgt_3,
	input  logic                      commit_takb_3,
	output btb_types_pkg::pc_t        fetch_pc,
	output logic                      takb
);

	// ========================================================================
	// Internal nets
	// ========================================================================
	btb_types_pkg::btb_entry_t           lookup_entry;   // Table read at fetch_pc
	btb_types_pkg::btb_entry_t           wr_entry;
	logic [btb_cfg_pkg::INDEX_WIDTH-1:0] wr_index;
	logic                                wr_en;
	logic                                push;
	logic                                pop;
	btb_types_pkg::pc_t                  push_pc;
	btb_types_pkg::pc_t                  ras_top;

	btb_table btb_table_inst (
		.clk(clk), .rst(rst),
		.wr_en(wr_en), .wr_index(wr_index), .wr_entry(wr_entry),
		.fetch_pc(fetch_pc), .lookup_entry(lookup_entry)
	);

	// Retire side, one write per cycle at most
	btb_commit_select btb_commit_select_inst (
		.clk(clk), .rst(rst),
		.commit_kind_0(commit_kind_0), .commit_kind_1(commit_kind_1),
		.commit_kind_2(commit_kind_2), .commit_kind_3(commit_kind_3),
		.commit_pc_0(commit_pc_0), .commit_pc_1(commit_pc_1),
		.commit_pc_2(commit_pc_2), .commit_pc_3(commit_pc_3),
		.commit_tgt_0(commit_tgt_0), .commit_tgt_1(commit_tgt_1),
		.commit_tgt_2(commit_tgt_2), .commit_tgt_3(commit_tgt_3),
		.commit_takb_0(commit_takb_0), .commit_takb_1(commit_takb_1),
		.commit_takb_2(commit_takb_2), .commit_takb_3(commit_takb_3),
		.wr_en(wr_en), .wr_index(wr_index), .wr_entry(wr_entry)
	);

	btb_ras btb_ras_inst (
		.clk(clk), .rst(rst),
		.push(push), .pop(pop), .push_pc(push_pc),
		.ras_top(ras_top)
	);

	// Fetch side
	btb_next_pc btb_next_pc_inst (
		.clk(clk), .rst(rst), .advance(advance),
		.branchmiss(branchmiss), .misspc(misspc),
		.predicted_correctly_dec(predicted_correctly_dec),
		.new_address_dec(new_address_dec),
		.p_override(p_override), .new_address_ext(new_address_ext),
		.lookup_entry(lookup_entry), .ras_top(ras_top),
		.fetch_pc(fetch_pc), .takb(takb),
		.push(push), .pop(pop), .push_pc(push_pc)
	);

endmodule

`default_nettype wire

/* hdl/btb_next_pc.sv */
// Next fetch address selection by fixed priority and the fetch address register
`timescale 1ns/1ps
`default_nettype none

module btb_next_pc (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      advance,                  // Fetch may move on
	input  logic                      branchmiss,
	input  btb_types_pkg::pc_t        misspc,
	input  logic                      predicted_correctly_dec,  // Low asks for a redirect
	input  btb_types_pkg::pc_t        new_address_dec,
	input  logic                      p_override,
	input  btb_types_pkg::pc_t        new_address_ext,
	input  btb_types_pkg::btb_entry_t lookup_entry,
	input  btb_types_pkg::pc_t        ras_top,
	output btb_types_pkg::pc_t        fetch_pc,
	output logic                      takb,
	output logic                      push,
	output logic                      pop,
	output btb_types_pkg::pc_t        push_pc
);

	btb_types_pkg::pc_t next_pc;      // Address loaded at the next advancing edge
	btb_types_pkg::pc_t seq_pc;       // Following fetch group
	logic               hit;          // Table entry matches current fetch address
	logic               correction;   // One of the three external redirects is active

	// ========================================================================
	// Hit detection and sequential address
	// ========================================================================
	assign hit = (lookup_entry.kind != btb_types_pkg::FLOW_NONE) &&
	             (lookup_entry.pc == fetch_pc);   // Full tag compare
	assign correction = branchmiss || !predicted_correctly_dec || p_override;
	assign seq_pc = fetch_pc + btb_types_pkg::pc_t'(btb_cfg_pkg::GROUP_BYTES);

	// ========================================================================
	// Priority select
	// ========================================================================
	always_comb begin
		next_pc = seq_pc;   // Default sequential advance
		takb    = 1'b0;
		if (branchmiss)
			next_pc = misspc;              // Commit stage knows best
		else if (!predicted_correctly_dec)
			next_pc = new_address_dec;     // Decode correction
		else if (p_override)
			next_pc = new_address_ext;     // External predictor
		else if (hit) begin
			case (lookup_entry.kind)
				btb_types_pkg::FLOW_RET: next_pc = ras_top;
				btb_types_pkg::FLOW_BRANCH: begin
					next_pc = lookup_entry.tgt;
					takb    = lookup_entry.takb;   // Redirect even when recorded not taken
				end
				default: next_pc = lookup_entry.tgt;   // Call and jump
			endcase
		end
	end

	// Stack traffic only when the hit really steers fetch at this edge
	assign push    = advance && !correction && hit &&
	                 (lookup_entry.kind == btb_types_pkg::FLOW_CALL);
	assign pop     = advance && !correction && hit &&
	                 (lookup_entry.kind == btb_types_pkg::FLOW_RET);
	assign push_pc = seq_pc;   // Return lands on the group after the call

	// Fetch address register, holds while advance is low
	always_ff @(posedge clk) begin
		if (rst)
			fetch_pc <= btb_cfg_pkg::RESET_PC;
		else if (advance)
			fetch_pc <= next_pc;
	end

endmodule

`default_nettype wire

/* hdl/btb_ras.sv */
// Return-address stack, pushed on call hits and popped on return hits by the fetch logic
`timescale 1ns/1ps
`default_nettype none

module btb_ras (
	input  logic               clk,
	input  logic               rst,
	input  logic               push,
	input  logic               pop,
	input  btb_types_pkg::pc_t push_pc,
	output btb_types_pkg::pc_t ras_top
);

	// ========================================================================
	// Stack storage and pointer
	// ========================================================================
	btb_types_pkg::pc_t ras_mem [btb_cfg_pkg::RAS_DEPTH];

	logic [btb_cfg_pkg::RAS_PTR_WIDTH-1:0] sp;          // Points at the top entry
	logic [btb_cfg_pkg::RAS_PTR_WIDTH-1:0] push_slot;   // Slot just below the top

	// Stack grows downward, wraps silently when over- or under-run
	assign push_slot = sp - 1'b1;

	// Pointer counter
	always_ff @(posedge clk) begin
		if (rst) begin
			sp <= '0;
		end
		else begin
			case ({push, pop})
				2'b10:   sp <= push_slot;     // Call
				2'b01:   sp <= sp + 1'b1;     // Return
				default: sp <= sp;            // Idle, or both which fetch never raises
			endcase
		end
	end

	// Entry writes
	always_ff @(posedge clk) begin
		if (rst) begin
			// An unmatched return lands on the boot vector
			for (int i = 0; i < btb_cfg_pkg::RAS_DEPTH; i++) begin
				ras_mem[i] <= btb_cfg_pkg::RESET_PC;
			end
		end
		else if (push && !pop) begin
			ras_mem[push_slot] <= push_pc;
		end
	end

	// ========================================================================
	// Top of stack
	// ========================================================================
	// Combinational so a return hit redirects in its own lookup cycle
	assign ras_top = ras_mem[sp];

endmodule

`default_nettype wire

/* hdl/btb_commit_select.sv */
// Picks the lowest active of four retiring flow changes and registers it as a table write
`timescale 1ns/1ps
`default_nettype none

module btb_commit_select (
	input  logic                                 clk,
	input  logic                                 rst,
	input  btb_types_pkg::flow_kind_e            commit_kind_0,
	input  btb_types_pkg::flow_kind_e            commit_kind_1,
	input  btb_types_pkg::flow_kind_e            commit_kind_2,
	input  btb_types_pkg::flow_kind_e            commit_kind_3,
	input  btb_types_pkg::pc_t                   commit_pc_0,
	input  btb_types_pkg::pc_t                   commit_pc_1,
	input  btb_types_pkg::pc_t                   commit_pc_2,
	input  btb_types_pkg::pc_t                   commit_pc_3,
	input  btb_types_pkg::pc_t                   commit_tgt_0,
	input  btb_types_pkg::pc_t                   commit_tgt_1,
	input  btb_types_pkg::pc_t                   commit_tgt_2,
	input  btb_types_pkg::pc_t                   commit_tgt_3,
	input  logic                                 commit_takb_0,
	input  logic                                 commit_takb_1,
	input  logic                                 commit_takb_2,
	input  logic                                 commit_takb_3,
	output logic                                 wr_en,
	output logic [btb_cfg_pkg::INDEX_WIDTH-1:0]  wr_index,
	output btb_types_pkg::btb_entry_t            wr_entry
);

	btb_types_pkg::btb_entry_t sel_entry;   // Entry of the winning slot
	logic                      sel_valid;   // Some slot retired a flow change

	// ========================================================================
	// Slot priority, slot 0 first
	// ========================================================================
	always_comb begin
		sel_entry = '0;
		sel_valid = 1'b1;
		if (commit_kind_0 != btb_types_pkg::FLOW_NONE)
			sel_entry = '{commit_kind_0, commit_takb_0, commit_pc_0, commit_tgt_0};
		else if (commit_kind_1 != btb_types_pkg::FLOW_NONE)
			sel_entry = '{commit_kind_1, commit_takb_1, commit_pc_1, commit_tgt_1};
		else if (commit_kind_2 != btb_types_pkg::FLOW_NONE)
			sel_entry = '{commit_kind_2, commit_takb_2, commit_pc_2, commit_tgt_2};
		else if (commit_kind_3 != btb_types_pkg::FLOW_NONE)
			sel_entry = '{commit_kind_3, commit_takb_3, commit_pc_3, commit_tgt_3};
		else
			sel_valid = 1'b0;   // Quiet retire cycle
	end

	// Write strobe, high for exactly one cycle per retire cycle with a flow change
	always_ff @(posedge clk) begin
		if (rst)
			wr_en <= 1'b0;
		else
			wr_en <= sel_valid;
	end

	// Payload follows the selection every cycle and only matters under wr_en
	always_ff @(posedge clk) begin
		wr_entry <= sel_entry;
		wr_index <= sel_entry.pc[btb_cfg_pkg::INDEX_WIDTH:1];   // Same bits the lookup uses
	end

endmodule

`default_nettype wire

/* hdl/btb_table.sv */
// Direct-mapped target table, written one clock after commit and read combinationally
`timescale 1ns/1ps
`default_nettype none

module btb_table (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 wr_en,
	input  logic [btb_cfg_pkg::INDEX_WIDTH-1:0]  wr_index,
	input  btb_types_pkg::btb_entry_t            wr_entry,
	input  btb_types_pkg::pc_t                   fetch_pc,
	output btb_types_pkg::btb_entry_t            lookup_entry
);

	// ========================================================================
	// Storage
	// ========================================================================
	btb_types_pkg::btb_entry_t table_mem [btb_cfg_pkg::TABLE_DEPTH];

	logic [btb_cfg_pkg::INDEX_WIDTH-1:0] rd_index;   // Lookup index from fetch address

	// Bit 0 carries no information since instructions sit on even addresses
	assign rd_index = fetch_pc[btb_cfg_pkg::INDEX_WIDTH:1];

	// Write port
	always_ff @(posedge clk) begin
		if (rst) begin
			// Every slot starts out empty so no lookup can hit
			for (int i = 0; i < btb_cfg_pkg::TABLE_DEPTH; i++) begin
				table_mem[i] <= '0;    // kind field decodes to FLOW_NONE
			end
		end
		else if (wr_en) begin
			table_mem[wr_index] <= wr_entry;   // Newer retire replaces older entry
		end
	end

	// ========================================================================
	// Lookup
	// ========================================================================
	// Read is asynchronous so the hit resolves in the same cycle as fetch_pc
	// A write at this edge is visible to the lookup right after it
	assign lookup_entry = table_mem[rd_index];

endmodule

`default_nettype wire

/* hdl/btb_types_pkg.sv */
// Address, flow-kind and table-entry types shared by the predictor RTL
`default_nettype none

package btb_types_pkg;

	// Byte address of an instruction group or target
	typedef logic [btb_cfg_pkg::PC_WIDTH-1:0] pc_t;

	// Kind of change of flow recorded for a retired instruction
	typedef enum logic [2:0] {
		FLOW_NONE   = 3'd0,    // Empty entry or idle commit slot
		FLOW_BRANCH = 3'd1,    // Conditional, carries a taken bit
		FLOW_JUMP   = 3'd2,
		FLOW_CALL   = 3'd3,    // Pushes the return address
		FLOW_RET    = 3'd4     // Target comes from the return stack
	} flow_kind_e;

	// One table entry, 68 bits
	typedef struct packed {
		flow_kind_e kind;      // FLOW_NONE marks the slot empty
		logic       takb;      // Last resolved direction for branches
		pc_t        pc;        // Full source address, used as the tag
		pc_t        tgt;       // Target address
	} btb_entry_t;

endpackage

`default_nettype wire

/* hdl/btb_cfg_pkg.sv */
// Predictor sizes and constants, referenced by scoped name from the RTL and the testbench
`default_nettype none

package btb_cfg_pkg;

	// ========================================================================
	// Address and table geometry
	// ========================================================================
	localparam int PC_WIDTH    = 32;           // Byte address width
	localparam int INDEX_WIDTH = 6;            // Table index taken from pc[6:1]
	localparam int TABLE_DEPTH = 64;           // One entry per index value

	// ========================================================================
	// Return stack and fetch
	// ========================================================================
	localparam int RAS_PTR_WIDTH = 5;          // Wraps naturally at RAS_DEPTH
	localparam int RAS_DEPTH     = 32;
	localparam int GROUP_BYTES   = 24;         // Four six-byte instructions per group

	// Boot vector
	localparam logic [PC_WIDTH-1:0] RESET_PC = 32'hFFFC_0000;

	// Retire width
	localparam int COMMIT_SLOTS = 4;

endpackage

`default_nettype wire
